// ==== lsq_defs.svh ====
//==========================================================================
// Load/store queue parameters
// Queue depth and the datapath widths used across the design
//==========================================================================

`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// Queue depth and the matching position width
`define LSQ_ENTRIES 8
`define LSQ_IDX_W   3

// Reorder-buffer tag width
`define ROB_IDX_W   5

// Narrow word address makes same-address pairs common
`define ADDR_W      8

// Whole-word data only
`define DATA_W      32

`endif

// ==== lsq_pkg.sv ====
//==========================================================================
// Load/store queue types
// Width typedefs, command and entry-state enums, exported entry status
//==========================================================================

`include "lsq_defs.svh"

package lsq_pkg;

    // Widths that carry a meaning
    typedef logic [`LSQ_IDX_W-1:0] lsq_idx_t;
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [`ADDR_W-1:0]    addr_t;
    typedef logic [`DATA_W-1:0]    data_t;

    // Entry command, none marks a free slot
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_LOAD  = 2'd1,
        CMD_STORE = 2'd2
    } lsq_cmd_e;

    // Per-entry life cycle
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_ADDR    = 3'd1,
        ST_DEPEND  = 3'd2,
        ST_RD_MEM  = 3'd3,
        ST_LOAD_CP = 3'd4,
        ST_RETIRE  = 3'd5,
        ST_WR_MEM  = 3'd6
    } lsq_state_e;

    // Status each entry shows to the rest of the queue
    typedef struct packed {
        lsq_state_e state;
        lsq_cmd_e   cmd;
        rob_idx_t   rob_idx;
        addr_t      addr;
        logic       addr_valid;
        data_t      data;
        logic       data_valid;
    } lsq_entry_t;

endpackage

// ==== lsq_mem_if.sv ====
//==========================================================================
// Entry to arbiter memory link
// One entry's request fields toward the shared memory port
//==========================================================================

`timescale 1ns/1ns

interface lsq_mem_if;

    import lsq_pkg::*;

    // Request side, held stable until done
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;

    // Single-cycle completion with read word
    logic  done;
    data_t rdata;

    modport entry (
        output req, we, addr, wdata,
        input  done, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output done, rdata
    );

endinterface

// ==== lsq_entry_ctrl.sv ====
//==========================================================================
// Load/store queue entry
// Holds one instruction from dispatch through memory access to free
//==========================================================================

`timescale 1ns/1ns

module lsq_entry_ctrl (
    input  logic                clk_i,
    input  logic                rst_i,
    input  lsq_pkg::lsq_idx_t   entry_idx_i,
    input  logic                dp_load_i,
    input  lsq_pkg::lsq_cmd_e   dp_cmd_i,
    input  lsq_pkg::rob_idx_t   dp_rob_idx_i,
    input  logic                fu_valid_i,
    input  lsq_pkg::rob_idx_t   fu_rob_idx_i,
    input  lsq_pkg::addr_t      fu_addr_i,
    input  lsq_pkg::data_t      fu_data_i,
    input  logic                older_known_i,
    input  logic                fwd_hit_i,
    input  lsq_pkg::data_t      fwd_data_i,
    input  logic                cp_grant_i,
    input  logic                retire_i,
    lsq_mem_if.entry            mem,
    output lsq_pkg::lsq_entry_t entry_o
);

    import lsq_pkg::*;

    lsq_entry_t entry_q;
    lsq_entry_t entry_d;
    logic       fu_hit;
    logic       at_head;

    // Writeback tag match only while waiting for the address
    assign fu_hit = fu_valid_i && (entry_q.state == ST_ADDR) &&
                    (fu_rob_idx_i == entry_q.rob_idx);

    // Position is counted from the head, so zero is the oldest entry
    assign at_head = (entry_idx_i == '0);

    //======================================================================
    // Next-state and field update
    //======================================================================
    always_comb begin
        entry_d = entry_q;
        case (entry_q.state)
            ST_IDLE: begin
                if (dp_load_i) begin
                    entry_d.state   = ST_ADDR;
                    entry_d.cmd     = dp_cmd_i;
                    entry_d.rob_idx = dp_rob_idx_i;
                end
            end
            ST_ADDR: begin
                if (fu_hit) begin
                    entry_d.addr       = fu_addr_i;
                    entry_d.addr_valid = 1'b1;
                    // Store is complete once its data is here
                    if (entry_q.cmd == CMD_STORE) begin
                        entry_d.data       = fu_data_i;
                        entry_d.data_valid = 1'b1;
                        entry_d.state      = ST_RETIRE;
                    end else begin
                        entry_d.state = ST_DEPEND;
                    end
                end
            end
            ST_DEPEND: begin
                // Wait for every older store address
                if (older_known_i) begin
                    if (fwd_hit_i) begin
                        entry_d.data       = fwd_data_i;
                        entry_d.data_valid = 1'b1;
                        entry_d.state      = ST_LOAD_CP;
                    end else begin
                        entry_d.state = ST_RD_MEM;
                    end
                end
            end
            ST_RD_MEM: begin
                // Read word arrives with done
                if (mem.done) begin
                    entry_d.data       = mem.rdata;
                    entry_d.data_valid = 1'b1;
                    entry_d.state      = ST_LOAD_CP;
                end
            end
            ST_LOAD_CP: begin
                if (cp_grant_i) begin
                    entry_d.state = ST_RETIRE;
                end
            end
            ST_RETIRE: begin
                if (retire_i && at_head) begin
                    if (entry_q.cmd == CMD_LOAD) begin
                        entry_d = '0;
                    end else begin
                        entry_d.state = ST_WR_MEM;
                    end
                end
            end
            ST_WR_MEM: begin
                // Slot stays busy until memory holds the store
                if (mem.done) begin
                    entry_d = '0;
                end
            end
            default: begin
                entry_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            entry_q <= '0;
        end else begin
            entry_q <= entry_d;
        end
    end

    // Memory request for a load read or a retired store write
    assign mem.req   = (entry_q.state == ST_RD_MEM) || (entry_q.state == ST_WR_MEM);
    assign mem.we    = (entry_q.state == ST_WR_MEM);
    assign mem.addr  = entry_q.addr;
    assign mem.wdata = entry_q.data;

    assign entry_o = entry_q;

endmodule

// ==== lsq_dep_check.sv ====
//==========================================================================
// Store-to-load dependency check
// Per entry, older store address status and the forwarding source
//==========================================================================

`timescale 1ns/1ns

`include "lsq_defs.svh"

module lsq_dep_check (
    input  lsq_pkg::lsq_idx_t                      head_i,
    input  lsq_pkg::lsq_entry_t [`LSQ_ENTRIES-1:0] entries_i,
    output logic                [`LSQ_ENTRIES-1:0] older_known_o,
    output logic                [`LSQ_ENTRIES-1:0] fwd_hit_o,
    output lsq_pkg::data_t      [`LSQ_ENTRIES-1:0] fwd_data_o
);

    import lsq_pkg::*;

    // Age is the distance from head, wrapping with the index width
    always_comb begin
        lsq_idx_t age_j;
        lsq_idx_t pos_k;
        for (int j = 0; j < `LSQ_ENTRIES; j++) begin
            older_known_o[j] = 1'b1;
            fwd_hit_o[j]     = 1'b0;
            fwd_data_o[j]    = '0;
            age_j            = lsq_idx_t'(j) - head_i;
            // Walk oldest to youngest, later hits overwrite
            for (int d = 0; d < `LSQ_ENTRIES; d++) begin
                pos_k = head_i + lsq_idx_t'(d);
                if ((lsq_idx_t'(d) < age_j) && (entries_i[pos_k].cmd == CMD_STORE)) begin
                    if (!entries_i[pos_k].addr_valid) begin
                        // Unknown older store address blocks the load
                        older_known_o[j] = 1'b0;
                    end else if (entries_i[pos_k].addr == entries_i[j].addr) begin
                        fwd_hit_o[j]  = 1'b1;
                        fwd_data_o[j] = entries_i[pos_k].data;
                    end
                end
            end
        end
    end

endmodule

// ==== lsq_port_arbiter.sv ====
//==========================================================================
// Memory port and completion bus arbiter
// Four-phase memory handshake for one entry, load completion select
//==========================================================================

`timescale 1ns/1ns

`include "lsq_defs.svh"

module lsq_port_arbiter (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    lsq_mem_if.arbiter                             mem [`LSQ_ENTRIES],
    input  lsq_pkg::lsq_entry_t [`LSQ_ENTRIES-1:0] entries_i,
    output logic                [`LSQ_ENTRIES-1:0] cp_grant_o,
    output logic                                   mem_req_o,
    output logic                                   mem_we_o,
    output lsq_pkg::addr_t                         mem_addr_o,
    output lsq_pkg::data_t                         mem_wdata_o,
    input  logic                                   mem_ack_i,
    input  lsq_pkg::data_t                         mem_rdata_i,
    output logic                                   cp_valid_o,
    output lsq_pkg::rob_idx_t                      cp_rob_idx_o,
    output lsq_pkg::data_t                         cp_data_o
);

    import lsq_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_REL
    } arb_state_e;

    arb_state_e                state_q;
    lsq_idx_t                  sel_q;
    lsq_idx_t                  req_pick;
    lsq_idx_t                  cp_pick;
    logic [`LSQ_ENTRIES-1:0]   req_vec;
    logic [`LSQ_ENTRIES-1:0]   we_vec;
    addr_t [`LSQ_ENTRIES-1:0]  addr_vec;
    data_t [`LSQ_ENTRIES-1:0]  wdata_vec;
    logic                      any_req;
    logic                      ack_hit;

    // First ack cycle of the granted request
    assign ack_hit = (state_q == ARB_WAIT_ACK) && mem_ack_i;

    // Flatten the interface array for indexed access
    for (genvar i = 0; i < `LSQ_ENTRIES; i++) begin : g_port
        assign req_vec[i]   = mem[i].req;
        assign we_vec[i]    = mem[i].we;
        assign addr_vec[i]  = mem[i].addr;
        assign wdata_vec[i] = mem[i].wdata;
        assign mem[i].done  = ack_hit && (sel_q == lsq_idx_t'(i));
        assign mem[i].rdata = mem_rdata_i;
    end

    // Lowest queue position wins
    always_comb begin
        any_req  = 1'b0;
        req_pick = '0;
        for (int i = `LSQ_ENTRIES - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                any_req  = 1'b1;
                req_pick = lsq_idx_t'(i);
            end
        end
    end

    //======================================================================
    // Four-phase handshake FSM
    //======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ARB_IDLE;
            sel_q   <= '0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (any_req) begin
                        sel_q   <= req_pick;
                        state_q <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (mem_ack_i) begin
                        state_q <= ARB_WAIT_REL;
                    end
                end
                // New request only after ack is back low
                ARB_WAIT_REL: begin
                    if (!mem_ack_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    assign mem_req_o   = (state_q == ARB_WAIT_ACK);
    assign mem_we_o    = we_vec[sel_q];
    assign mem_addr_o  = addr_vec[sel_q];
    assign mem_wdata_o = wdata_vec[sel_q];

    // Completion bus, lowest load waiting in load_cp
    always_comb begin
        cp_valid_o = 1'b0;
        cp_pick    = '0;
        for (int i = `LSQ_ENTRIES - 1; i >= 0; i--) begin
            if (entries_i[i].state == ST_LOAD_CP) begin
                cp_valid_o = 1'b1;
                cp_pick    = lsq_idx_t'(i);
            end
        end
    end

    always_comb begin
        cp_grant_o          = '0;
        cp_grant_o[cp_pick] = cp_valid_o;
    end

    assign cp_rob_idx_o = entries_i[cp_pick].rob_idx;
    assign cp_data_o    = entries_i[cp_pick].data;

endmodule

// ==== lsq_top.sv ====
//==========================================================================
// Load/store queue top
// Head/tail control, entry array, dependency check and port arbiter
//==========================================================================

`timescale 1ns/1ns

`include "lsq_defs.svh"

module lsq_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              dp_valid_i,
    input  lsq_pkg::lsq_cmd_e dp_cmd_i,
    input  lsq_pkg::rob_idx_t dp_rob_idx_i,
    output logic              dp_ready_o,
    input  logic              fu_valid_i,
    input  lsq_pkg::rob_idx_t fu_rob_idx_i,
    input  lsq_pkg::addr_t    fu_addr_i,
    input  lsq_pkg::data_t    fu_data_i,
    input  logic              rt_valid_i,
    output logic              rt_ready_o,
    output logic              cp_valid_o,
    output lsq_pkg::rob_idx_t cp_rob_idx_o,
    output lsq_pkg::data_t    cp_data_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output lsq_pkg::addr_t    mem_addr_o,
    output lsq_pkg::data_t    mem_wdata_o,
    input  logic              mem_ack_i,
    input  lsq_pkg::data_t    mem_rdata_i
);

    import lsq_pkg::*;

    lsq_idx_t                      head_q;
    lsq_idx_t                      tail_q;
    logic [`LSQ_IDX_W:0]           count_q;
    logic                          ready_q;
    logic                          dp_fire;
    logic                          rt_fire;
    logic                          head_free;
    lsq_entry_t [`LSQ_ENTRIES-1:0] entries;
    logic [`LSQ_ENTRIES-1:0]       older_known;
    logic [`LSQ_ENTRIES-1:0]       fwd_hit;
    logic [`LSQ_ENTRIES-1:0]       cp_grant;
    data_t [`LSQ_ENTRIES-1:0]      fwd_data;

    lsq_mem_if mem_if [`LSQ_ENTRIES] ();

    // Ready held off for one cycle out of reset
    assign dp_ready_o = ready_q && (count_q != (`LSQ_IDX_W+1)'(`LSQ_ENTRIES));
    assign dp_fire    = dp_valid_i && dp_ready_o;
    assign rt_ready_o = (entries[head_q].state == ST_RETIRE);
    assign rt_fire    = rt_valid_i && rt_ready_o;

    // Occupied head back in idle means it was retired and freed
    assign head_free  = (count_q != '0) && (entries[head_q].state == ST_IDLE);

    //======================================================================
    // Queue pointers and occupancy
    //======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            if (dp_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            if (head_free) begin
                head_q <= head_q + 1'b1;
            end
            case ({dp_fire, head_free})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry array, position passed as distance from head
    for (genvar i = 0; i < `LSQ_ENTRIES; i++) begin : g_entry
        lsq_entry_ctrl u_entry (
            .clk_i         (clk_i),
            .rst_i         (rst_i),
            .entry_idx_i   (lsq_idx_t'(i) - head_q),
            .dp_load_i     (dp_fire && (tail_q == lsq_idx_t'(i))),
            .dp_cmd_i      (dp_cmd_i),
            .dp_rob_idx_i  (dp_rob_idx_i),
            .fu_valid_i    (fu_valid_i),
            .fu_rob_idx_i  (fu_rob_idx_i),
            .fu_addr_i     (fu_addr_i),
            .fu_data_i     (fu_data_i),
            .older_known_i (older_known[i]),
            .fwd_hit_i     (fwd_hit[i]),
            .fwd_data_i    (fwd_data[i]),
            .cp_grant_i    (cp_grant[i]),
            .retire_i      (rt_fire),
            .mem           (mem_if[i]),
            .entry_o       (entries[i])
        );
    end

    lsq_dep_check u_dep_check (
        .head_i        (head_q),
        .entries_i     (entries),
        .older_known_o (older_known),
        .fwd_hit_o     (fwd_hit),
        .fwd_data_o    (fwd_data)
    );

    lsq_port_arbiter u_arbiter (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem          (mem_if),
        .entries_i    (entries),
        .cp_grant_o   (cp_grant),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .cp_valid_o   (cp_valid_o),
        .cp_rob_idx_o (cp_rob_idx_o),
        .cp_data_o    (cp_data_o)
    );

endmodule

// ==== tb_lsq.sv ====
//==========================================================================
// Load/store queue testbench
// Random program against a program-order model, memory responder, checks
//==========================================================================

`timescale 1ns/1ns

`include "lsq_defs.svh"

module tb_lsq;

    import lsq_pkg::*;

    localparam int unsigned SEED = 32'hb236;
    localparam int N_RANDOM = 200;
    localparam int N_BP     = 12;
    localparam int N_TOTAL  = N_RANDOM + N_BP;
    localparam int WATCHDOG_CYCLES = N_TOTAL * 200;
    localparam int MEM_WORDS = 1 << `ADDR_W;
    localparam int T_RESET = 1;
    localparam int T_LOAD  = 2;
    localparam int T_STORE = 3;
    localparam int T_HAND  = 4;
    localparam int T_BP    = 5;

    logic     clk_i = 1'b0;
    logic     rst_i;
    logic     dp_valid_i;
    lsq_cmd_e dp_cmd_i;
    rob_idx_t dp_rob_idx_i;
    logic     dp_ready_o;
    logic     fu_valid_i;
    rob_idx_t fu_rob_idx_i;
    addr_t    fu_addr_i;
    data_t    fu_data_i;
    logic     rt_valid_i;
    logic     rt_ready_o;
    logic     cp_valid_o;
    rob_idx_t cp_rob_idx_o;
    data_t    cp_data_o;
    logic     mem_req_o;
    logic     mem_we_o;
    addr_t    mem_addr_o;
    data_t    mem_wdata_o;
    logic     mem_ack_i;
    data_t    mem_rdata_i;

    // Program in order with the model's expected load values
    lsq_cmd_e prog_cmd  [N_TOTAL];
    addr_t    prog_addr [N_TOTAL];
    data_t    prog_data [N_TOTAL];
    data_t    prog_exp  [N_TOTAL];
    logic     prog_done [N_TOTAL];
    logic     prog_wb   [N_TOTAL];
    int       rob_seq   [1 << `ROB_IDX_W];
    logic     rob_live  [1 << `ROB_IDX_W];
    data_t    model_mem [MEM_WORDS];
    data_t    mem_image [MEM_WORDS];
    int       wb_pool[$];
    int       wr_queue[$];

    int gen_cnt = 0;
    int disp_ptr = 0;
    int ret_ptr = 0;
    int done_cnt = 0;
    int write_cnt = 0;
    int checks = 0;
    int errs [1:5] = '{default: 0};
    int cp_seq;
    int wr_seq;
    logic  prev_req;
    logic  prev_ack;
    logic  held_we;
    addr_t held_addr;
    data_t held_wdata;

    lsq_top dut (.*);

    always #4 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp, input int test_id);
        checks++;
        if (got !== exp) begin
            errs[test_id]++;
            $display("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic flag_failure(input int test_id, input string msg);
        errs[test_id]++;
        $display("Failure at %0t ns in test %0d: %s", $time, test_id, msg);
    endtask

    task automatic report_test(input int test_id, input string name);
        $display("Test %0d %s: %s, %0d error(s)", test_id, name,
                 (errs[test_id] == 0) ? "ok" : "FAILED", errs[test_id]);
    endtask

    // Distinct word per address spread over every address bit
    function automatic data_t fill_word(input int a);
        return (data_t'(a) * 32'h0101_0101) ^ 32'hc3a5_0000;
    endfunction

    // Append instructions while walking the model image in program order
    task automatic make_program(input int n_instr);
        addr_t a;
        for (int i = 0; i < n_instr; i++) begin
            // Mostly a small window so same-address pairs are common
            a = ($urandom_range(3, 0) != 0) ? addr_t'($urandom_range(15, 0)) : addr_t'($urandom);
            prog_addr[gen_cnt] = a;
            prog_data[gen_cnt] = $urandom;
            prog_done[gen_cnt] = 1'b0;
            prog_wb[gen_cnt]   = 1'b0;
            if ($urandom_range(1, 0) != 0) begin
                prog_cmd[gen_cnt] = CMD_LOAD;
                prog_exp[gen_cnt] = model_mem[a];
            end else begin
                prog_cmd[gen_cnt] = CMD_STORE;
                model_mem[a]      = prog_data[gen_cnt];
            end
            gen_cnt++;
        end
    endtask

    //======================================================================
    // Four-phase memory responder with a random 0 to 4 cycle delay
    //======================================================================
    task automatic respond_memory();
        int delay;
        forever begin
            @(negedge clk_i);
            if (!rst_i && mem_req_o) begin
                delay = $urandom_range(4, 0);
                repeat (delay) @(negedge clk_i);
                if (mem_we_o) begin
                    mem_image[mem_addr_o] = mem_wdata_o;
                end else begin
                    mem_rdata_i = mem_image[mem_addr_o];
                end
                mem_ack_i = 1'b1;
                do @(negedge clk_i); while (mem_req_o);
                // Ack may linger a few cycles after the request drops
                delay = $urandom_range(2, 0);
                repeat (delay) @(negedge clk_i);
                mem_ack_i = 1'b0;
            end
        end
    endtask

    task automatic watchdog();
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, the queue did not drain", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Dispatch, writeback and retire one phase until fully drained
    task automatic run_phase(input int n_instr, input int hold_cycles);
        int cycle;
        int first;
        int pend;
        int pick;
        int seq;
        make_program(n_instr);
        first = disp_ptr;
        cycle = 0;
        pend  = -1;
        while (ret_ptr < gen_cnt || wr_queue.size() != 0) begin
            @(negedge clk_i);
            dp_valid_i = 1'b0;
            fu_valid_i = 1'b0;
            rt_valid_i = 1'b0;
            // Last cycle's dispatch now sits in addr state
            if (pend >= 0) begin
                wb_pool.push_back(pend);
                pend = -1;
            end
            if (cycle < hold_cycles && disp_ptr - first >= `LSQ_ENTRIES) begin
                check_value("dp_ready_o", dp_ready_o, 1'b0, T_BP);
            end
            if (hold_cycles > 0 && cycle == hold_cycles) begin
                check_value("dispatch count", disp_ptr - first, `LSQ_ENTRIES, T_BP);
            end
            if (disp_ptr < gen_cnt && dp_ready_o && $urandom_range(3, 0) != 0) begin
                dp_valid_i   = 1'b1;
                dp_cmd_i     = prog_cmd[disp_ptr];
                dp_rob_idx_i = rob_idx_t'(disp_ptr);
                rob_seq[dp_rob_idx_i]  = disp_ptr;
                rob_live[dp_rob_idx_i] = 1'b1;
                pend = disp_ptr;
                disp_ptr++;
            end
            if (wb_pool.size() != 0 && $urandom_range(1, 0) != 0) begin
                pick = $urandom_range(wb_pool.size() - 1, 0);
                seq  = wb_pool[pick];
                wb_pool.delete(pick);
                fu_valid_i   = 1'b1;
                fu_rob_idx_i = rob_idx_t'(seq);
                fu_addr_i    = prog_addr[seq];
                fu_data_i    = prog_data[seq];
                prog_wb[seq] = 1'b1;
            end
            if (cycle >= hold_cycles && rt_ready_o && $urandom_range(1, 0) != 0) begin
                // Head is always the oldest unretired instruction
                seq = ret_ptr;
                rt_valid_i = 1'b1;
                if (prog_cmd[seq] == CMD_LOAD && !prog_done[seq]) begin
                    flag_failure(T_LOAD, "load offered for retire before its completion");
                end
                if (prog_cmd[seq] == CMD_STORE) begin
                    if (!prog_wb[seq]) begin
                        flag_failure(T_STORE, "store offered for retire before its writeback");
                    end
                    wr_queue.push_back(seq);
                end
                rob_live[rob_idx_t'(seq)] = 1'b0;
                ret_ptr++;
            end
            cycle++;
        end
        @(negedge clk_i);
        dp_valid_i = 1'b0;
        fu_valid_i = 1'b0;
        rt_valid_i = 1'b0;
        while (mem_req_o || mem_ack_i) @(negedge clk_i);
        repeat (2) @(negedge clk_i);
    endtask

    // Completion bus monitor
    always @(posedge clk_i) begin
        if (!rst_i && cp_valid_o) begin
            cp_seq = rob_seq[cp_rob_idx_o];
            if (!rob_live[cp_rob_idx_o] || prog_cmd[cp_seq] != CMD_LOAD || prog_done[cp_seq]) begin
                flag_failure(T_LOAD, $sformatf("completion for rob %0d, not a waiting load",
                                               cp_rob_idx_o));
            end else begin
                check_value($sformatf("cp_data_o (rob %0d)", cp_rob_idx_o), cp_data_o,
                            prog_exp[cp_seq], T_LOAD);
                prog_done[cp_seq] = 1'b1;
                done_cnt++;
            end
        end
    end

    // Store writes in retire order on the first ack cycle
    always @(posedge clk_i) begin
        if (!rst_i && mem_req_o && mem_ack_i && mem_we_o) begin
            if (wr_queue.size() == 0) begin
                flag_failure(T_STORE, "memory write with no retired store waiting");
            end else begin
                wr_seq = wr_queue.pop_front();
                check_value("mem_addr_o", mem_addr_o, prog_addr[wr_seq], T_STORE);
                check_value("mem_wdata_o", mem_wdata_o, prog_data[wr_seq], T_STORE);
                write_cnt++;
            end
        end
    end

    // Four-phase legality and request field stability
    always @(posedge clk_i) begin
        if (rst_i) begin
            prev_req = 1'b0;
            prev_ack = 1'b0;
        end else begin
            if (mem_req_o && !prev_req && prev_ack) begin
                flag_failure(T_HAND, "mem_req_o rose while mem_ack_i was still high");
            end
            if (mem_req_o && prev_req) begin
                check_value("mem_we_o", mem_we_o, held_we, T_HAND);
                check_value("mem_addr_o", mem_addr_o, held_addr, T_HAND);
                check_value("mem_wdata_o", mem_wdata_o, held_wdata, T_HAND);
            end
            prev_req   = mem_req_o;
            prev_ack   = mem_ack_i;
            held_we    = mem_we_o;
            held_addr  = mem_addr_o;
            held_wdata = mem_wdata_o;
        end
    end

    //======================================================================
    // Test sequence
    //======================================================================
    initial begin
        void'($urandom(SEED));
        rst_i        = 1'b1;
        dp_valid_i   = 1'b0;
        dp_cmd_i     = CMD_NONE;
        dp_rob_idx_i = '0;
        fu_valid_i   = 1'b0;
        fu_rob_idx_i = '0;
        fu_addr_i    = '0;
        fu_data_i    = '0;
        rt_valid_i   = 1'b0;
        mem_ack_i    = 1'b0;
        mem_rdata_i  = '0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem_image[a] = fill_word(a);
            model_mem[a] = fill_word(a);
        end
        for (int r = 0; r < (1 << `ROB_IDX_W); r++) begin
            rob_seq[r]  = 0;
            rob_live[r] = 1'b0;
        end
        fork
            respond_memory();
            watchdog();
        join_none
        repeat (10) @(negedge clk_i);
        rst_i = 1'b0;
        // Ready comes up one cycle after reset
        check_value("dp_ready_o", dp_ready_o, 1'b0, T_RESET);
        @(negedge clk_i);
        check_value("dp_ready_o", dp_ready_o, 1'b1, T_RESET);
        check_value("mem_req_o", mem_req_o, 1'b0, T_RESET);
        check_value("cp_valid_o", cp_valid_o, 1'b0, T_RESET);
        check_value("rt_ready_o", rt_ready_o, 1'b0, T_RESET);
        report_test(T_RESET, "reset outputs");
        run_phase(N_RANDOM, 0);
        report_test(T_LOAD, "load values");
        // Retire held back so the queue fills up
        run_phase(N_BP, 80);
        check_value("dp_ready_o", dp_ready_o, 1'b1, T_BP);
        check_value("rt_ready_o", rt_ready_o, 1'b0, T_BP);
        check_value("cp_valid_o", cp_valid_o, 1'b0, T_BP);
        report_test(T_BP, "back-pressure and drain");
        for (int a = 0; a < MEM_WORDS; a++) begin
            check_value($sformatf("mem_image[%0d]", a), mem_image[a], model_mem[a], T_STORE);
        end
        report_test(T_STORE, "store order and final memory");
        report_test(T_HAND, "memory handshake");
        $display("Summary: 5 tests, %0d checks, %0d errors, %0d loads done, %0d stores written",
                 checks, errs[1] + errs[2] + errs[3] + errs[4] + errs[5], done_cnt, write_cnt);
        if (errs[1] + errs[2] + errs[3] + errs[4] + errs[5] == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
lsq_pkg.sv
lsq_mem_if.sv
lsq_entry_ctrl.sv
lsq_dep_check.sv
lsq_port_arbiter.sv
lsq_top.sv
tb_lsq.sv

// ==== Bender.yml ====
package:
  name: lsq

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lsq_pkg.sv
      - lsq_mem_if.sv
      - lsq_entry_ctrl.sv
      - lsq_dep_check.sv
      - lsq_port_arbiter.sv
      - lsq_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsq.sv
